// File: files.f
rtl/ao_periph_pkg.sv
rtl/ao_reg_decoder.sv
rtl/soc_ctrl.sv
rtl/fast_intr_ctrl.sv
rtl/gpio_ao.sv
rtl/ao_peripheral_subsystem.sv
tb/ao_periph_checker.sv
tb/tb_ao_peripheral_subsystem.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_ao_peripheral_subsystem -f files.f &&
./obj_dir/Vtb_ao_peripheral_subsystem | tee /dev/stderr | grep -q "^Test passed$" ||
{ echo "Simulation did not report a pass" >&2; exit 1; }

// File: tb/tb_ao_peripheral_subsystem.sv
`timescale 1ns/100ps
// Random register traffic from a fixed-seed LFSR with one access in flight at a time
// Pads and straps move only while the bus is idle; ao_periph_checker does the comparing
module tb_ao_peripheral_subsystem;
  import ao_periph_pkg::*;

  localparam int unsigned FAST_INTR_W  = 15;
  localparam int unsigned GPIO_W       = 8;
  localparam int unsigned NUM_ACCESSES = 400;
  // Reset, 3 cycles per access and at worst a 4-cycle pin wait after each, plus margin
  localparam int unsigned TIMEOUT_CYCLES = 3000;

  logic                   clk;
  logic                   reset;
  ao_reg_req_t            bus_req;
  ao_reg_rsp_t            bus_rsp;
  logic                   boot_select;
  logic                   exec_flash;
  logic                   exit_valid;
  logic [31:0]            exit_value;
  logic [FAST_INTR_W-1:0] fast_intr_in;
  logic [FAST_INTR_W-1:0] fast_intr_out;
  logic [GPIO_W-1:0]      gpio_in;
  logic [GPIO_W-1:0]      gpio_out;
  logic [GPIO_W-1:0]      gpio_en;
  logic [GPIO_W-1:0]      gpio_intr;
  logic [31:0]            lfsr_q;
  int unsigned            cycle_cnt;
  int unsigned            value_errs;
  int unsigned            hs_errs;

  ao_peripheral_subsystem #(
    .FAST_INTR_W (FAST_INTR_W),
    .GPIO_W      (GPIO_W)
  ) ao_peripheral_subsystem_i (
    .clk_i                (clk),
    .reset_i              (reset),
    .bus_req_i            (bus_req),
    .bus_rsp_o            (bus_rsp),
    .boot_select_i        (boot_select),
    .execute_from_flash_i (exec_flash),
    .exit_valid_o         (exit_valid),
    .exit_value_o         (exit_value),
    .fast_intr_i          (fast_intr_in),
    .fast_intr_o          (fast_intr_out),
    .cio_gpio_i           (gpio_in),
    .cio_gpio_o           (gpio_out),
    .cio_gpio_en_o        (gpio_en),
    .intr_gpio_o          (gpio_intr)
  );

  ao_periph_checker #(
    .FAST_INTR_W (FAST_INTR_W),
    .GPIO_W      (GPIO_W)
  ) ao_periph_checker_i (
    .clk_i                (clk),
    .reset_i              (reset),
    .bus_req_i            (bus_req),
    .bus_rsp_i            (bus_rsp),
    .boot_select_i        (boot_select),
    .execute_from_flash_i (exec_flash),
    .exit_valid_i         (exit_valid),
    .exit_value_i         (exit_value),
    .fast_line_i          (fast_intr_in),
    .fast_pend_i          (fast_intr_out),
    .gpio_pad_i           (gpio_in),
    .gpio_out_i           (gpio_out),
    .gpio_en_i            (gpio_en),
    .gpio_intr_i          (gpio_intr),
    .value_errs_o         (value_errs),
    .hs_errs_o            (hs_errs)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
      ao_periph_checker_i.report_counts();
      $display("Test failed");
      $finish;
    end
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int unsigned n, output logic [31:0] val);
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  // Every wait goes through here, so the interrupt lines move each cycle
  task automatic next_cycle();
    logic [31:0] r1;
    logic [31:0] r2;
    @(posedge clk);
    take_bits(FAST_INTR_W, r1);
    take_bits(FAST_INTR_W, r2);
    // Sparse lines so that clears can be seen
    fast_intr_in <= r1[FAST_INTR_W-1:0] & r2[FAST_INTR_W-1:0];
  endtask

  task automatic do_access();
    ao_reg_req_t req;
    logic [31:0] region;
    logic [31:0] ofs;
    logic [31:0] wr;
    logic [31:0] data;
    periph_sel_t sel;
    take_bits(3, region);
    take_bits(3, ofs);
    take_bits(1, wr);
    take_bits(32, data);
    case (region % 5)
      0:       sel = SOC_CTRL_SEL;
      1:       sel = FAST_INTR_SEL;
      2:       sel = GPIO_SEL;
      3:       sel = 4'h7;
      default: sel = 4'hc;
    endcase
    req.valid = 1'b1;
    req.write = wr[0];
    req.addr  = {16'h0, sel, 7'h0, ofs[2:0], 2'b00};
    req.wdata = data;
    bus_req <= req;
    next_cycle();
    while (!bus_rsp.ready) begin
      next_cycle();
    end
    bus_req <= '0;
    // One idle cycle between accesses
    next_cycle();
  endtask

  task automatic change_pins();
    logic [31:0] r;
    take_bits(GPIO_W + 2, r);
    gpio_in     <= r[GPIO_W-1:0];
    boot_select <= r[GPIO_W];
    exec_flash  <= r[GPIO_W+1];
    repeat (4) next_cycle();
  endtask

  initial begin
    logic [31:0] pick;
    clk          = 1'b0;
    reset        = 1'b1;
    bus_req      = '0;
    boot_select  = 1'b0;
    exec_flash   = 1'b0;
    fast_intr_in = '0;
    gpio_in      = '0;
    lfsr_q       = 32'h35ec;
    repeat (8) next_cycle();
    reset <= 1'b0;
    for (int unsigned n = 0; n < NUM_ACCESSES; n++) begin
      do_access();
      take_bits(2, pick);
      if (pick[1:0] == 2'b00) begin
        change_pins();
      end
    end
    repeat (2) next_cycle();
    @(negedge clk);
    ao_periph_checker_i.report_counts();
    if (value_errs == 0 && hs_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: tb/ao_periph_checker.sv
`timescale 1ns/100ps
// Cycle model of the always-on registers, sampled on the rising edge
// Expects a host with at most one access in flight
module ao_periph_checker #(
  parameter int unsigned FAST_INTR_W = 15,
  parameter int unsigned GPIO_W      = 8
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  ao_periph_pkg::ao_reg_req_t bus_req_i,
  input  ao_periph_pkg::ao_reg_rsp_t bus_rsp_i,
  input  logic                       boot_select_i,
  input  logic                       execute_from_flash_i,
  input  logic                       exit_valid_i,
  input  logic [31:0]                exit_value_i,
  input  logic [FAST_INTR_W-1:0]     fast_line_i,
  input  logic [FAST_INTR_W-1:0]     fast_pend_i,
  input  logic [GPIO_W-1:0]          gpio_pad_i,
  input  logic [GPIO_W-1:0]          gpio_out_i,
  input  logic [GPIO_W-1:0]          gpio_en_i,
  input  logic [GPIO_W-1:0]          gpio_intr_i,
  output int unsigned                value_errs_o,
  output int unsigned                hs_errs_o
);
  import ao_periph_pkg::*;

  // Expected state as it stands after the previous edge
  typedef struct packed {
    logic                   ready;
    logic                   error;
    logic                   check_rdata;
    logic [31:0]            rdata;
    logic                   exit_valid;
    logic [31:0]            exit_value;
    logic [FAST_INTR_W-1:0] pend;
    logic [GPIO_W-1:0]      gpio_out;
    logic [GPIO_W-1:0]      gpio_en;
    logic [GPIO_W-1:0]      intr_en;
    logic [GPIO_W-1:0]      status;
    logic [GPIO_W-1:0]      sync1;
    logic [GPIO_W-1:0]      sync2;
    logic [GPIO_W-1:0]      sync3;
  } model_t;

  model_t                 m;
  periph_sel_t            sel;
  reg_ofs_t               ofs;
  logic                   accept;
  logic                   mapped;
  logic                   wr;
  logic [31:0]            rd;
  logic [FAST_INTR_W-1:0] clr_fast;
  logic [GPIO_W-1:0]      clr_gpio;

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      value_errs_o++;
      $display("error %s: expected %h, got %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic report_counts();
    $display("Checker: %0d value errors, %0d handshake errors", value_errs_o, hs_errs_o);
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      m            = '0;
      value_errs_o = 0;
      hs_errs_o    = 0;
    end else begin
      if (bus_rsp_i.ready !== m.ready) begin
        hs_errs_o++;
        if (m.ready) begin
          $display("Missing ready for the access accepted one cycle earlier, at %0t", $time);
        end else begin
          $display("Extra ready with no access outstanding, at %0t", $time);
        end
      end else if (m.ready && m.check_rdata) begin
        check_value("bus_rsp_o.rdata", m.rdata, bus_rsp_i.rdata);
      end
      // Error stays low outside an unmapped response
      check_value("bus_rsp_o.error", 32'(m.error), 32'(bus_rsp_i.error));
      check_value("exit_valid_o", 32'(m.exit_valid), 32'(exit_valid_i));
      check_value("exit_value_o", m.exit_value, exit_value_i);
      check_value("fast_intr_o", 32'(m.pend), 32'(fast_pend_i));
      check_value("cio_gpio_o", 32'(m.gpio_out), 32'(gpio_out_i));
      check_value("cio_gpio_en_o", 32'(m.gpio_en), 32'(gpio_en_i));
      check_value("intr_gpio_o", 32'(m.status), 32'(gpio_intr_i));

      sel    = bus_req_i.addr[15:12];
      ofs    = bus_req_i.addr[4:2];
      mapped = (sel == SOC_CTRL_SEL) || (sel == FAST_INTR_SEL) || (sel == GPIO_SEL);
      accept = bus_req_i.valid && !m.ready;
      wr     = accept && bus_req_i.write;

      // Read data from the state before this edge
      rd = '0;
      if (sel == SOC_CTRL_SEL) begin
        case (ofs)
          EXIT_VALID_OFS:  rd = 32'(m.exit_valid);
          EXIT_VALUE_OFS:  rd = m.exit_value;
          BOOT_SELECT_OFS: rd = 32'(boot_select_i);
          EXEC_FLASH_OFS:  rd = 32'(execute_from_flash_i);
          default:         rd = '0;
        endcase
      end else if (sel == FAST_INTR_SEL && ofs == FAST_PENDING_OFS) begin
        rd = 32'(m.pend);
      end else if (sel == GPIO_SEL) begin
        case (ofs)
          GPIO_IN_OFS:          rd = 32'(m.sync2);
          GPIO_OUT_OFS:         rd = 32'(m.gpio_out);
          GPIO_EN_OFS:          rd = 32'(m.gpio_en);
          GPIO_INTR_EN_OFS:     rd = 32'(m.intr_en);
          GPIO_INTR_STATUS_OFS: rd = 32'(m.status);
          default:              rd = '0;
        endcase
      end
      m.ready       = accept;
      m.error       = accept && !mapped;
      m.check_rdata = accept && (!bus_req_i.write || !mapped);
      m.rdata       = mapped ? rd : '0;

      if (wr && sel == SOC_CTRL_SEL && ofs == EXIT_VALID_OFS) begin
        m.exit_valid = bus_req_i.wdata[0];
      end
      if (wr && sel == SOC_CTRL_SEL && ofs == EXIT_VALUE_OFS) begin
        m.exit_value = bus_req_i.wdata;
      end

      // Set beats clear in both interrupt registers
      clr_fast = (wr && sel == FAST_INTR_SEL && ofs == FAST_PENDING_OFS) ?
                 bus_req_i.wdata[FAST_INTR_W-1:0] : '0;
      m.pend   = (m.pend & ~clr_fast) | fast_line_i;
      clr_gpio = (wr && sel == GPIO_SEL && ofs == GPIO_INTR_STATUS_OFS) ?
                 bus_req_i.wdata[GPIO_W-1:0] : '0;
      // Edge seen two flops behind the pad and gated by the enable before this write
      m.status = (m.status & ~clr_gpio) | (m.sync2 & ~m.sync3 & m.intr_en);
      if (wr && sel == GPIO_SEL) begin
        case (ofs)
          GPIO_OUT_OFS:     m.gpio_out = bus_req_i.wdata[GPIO_W-1:0];
          GPIO_EN_OFS:      m.gpio_en  = bus_req_i.wdata[GPIO_W-1:0];
          GPIO_INTR_EN_OFS: m.intr_en  = bus_req_i.wdata[GPIO_W-1:0];
          default:          ;
        endcase
      end
      m.sync3 = m.sync2;
      m.sync2 = m.sync1;
      m.sync1 = gpio_pad_i;
    end
  end

endmodule

// File: rtl/ao_peripheral_subsystem.sv
`timescale 1ns/100ps
// Always-on register peripherals behind one valid/ready register bus
// One access in flight at a time, answered one cycle after valid
module ao_peripheral_subsystem #(
  parameter int unsigned FAST_INTR_W = 15,
  parameter int unsigned GPIO_W      = 8
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  ao_periph_pkg::ao_reg_req_t bus_req_i,
  output ao_periph_pkg::ao_reg_rsp_t bus_rsp_o,
  input  logic                       boot_select_i,
  input  logic                       execute_from_flash_i,
  output logic                       exit_valid_o,
  output logic [31:0]                exit_value_o,
  input  logic [FAST_INTR_W-1:0]     fast_intr_i,
  output logic [FAST_INTR_W-1:0]     fast_intr_o,
  input  logic [GPIO_W-1:0]          cio_gpio_i,
  output logic [GPIO_W-1:0]          cio_gpio_o,
  output logic [GPIO_W-1:0]          cio_gpio_en_o,
  output logic [GPIO_W-1:0]          intr_gpio_o
);
  import ao_periph_pkg::*;

  ao_reg_req_t soc_req;
  ao_reg_rsp_t soc_rsp;
  ao_reg_req_t fast_req;
  ao_reg_rsp_t fast_rsp;
  ao_reg_req_t gpio_req;
  ao_reg_rsp_t gpio_rsp;

  ao_reg_decoder ao_reg_decoder_i (
    .clk_i,
    .reset_i,
    .bus_req_i,
    .bus_rsp_o,
    .soc_req_o  (soc_req),
    .fast_req_o (fast_req),
    .gpio_req_o (gpio_req),
    .soc_rsp_i  (soc_rsp),
    .fast_rsp_i (fast_rsp),
    .gpio_rsp_i (gpio_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .reset_i,
    .reg_req_i (soc_req),
    .reg_rsp_o (soc_rsp),
    .boot_select_i,
    .execute_from_flash_i,
    .exit_valid_o,
    .exit_value_o
  );

  fast_intr_ctrl #(
    .FAST_INTR_W (FAST_INTR_W)
  ) fast_intr_ctrl_i (
    .clk_i,
    .reset_i,
    .reg_req_i (fast_req),
    .reg_rsp_o (fast_rsp),
    .fast_intr_i,
    .fast_intr_o
  );

  gpio_ao #(
    .GPIO_W (GPIO_W)
  ) gpio_ao_i (
    .clk_i,
    .reset_i,
    .reg_req_i (gpio_req),
    .reg_rsp_o (gpio_rsp),
    .cio_gpio_i,
    .cio_gpio_o,
    .cio_gpio_en_o,
    .intr_gpio_o
  );

endmodule

// File: rtl/gpio_ao.sv
`timescale 1ns/100ps
// Inputs pass a two-flop synchroniser; edges are seen two cycles late
// Only rising edges raise interrupts; GPIO_W up to 32
module gpio_ao #(
  parameter int unsigned GPIO_W = 8
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  ao_periph_pkg::ao_reg_req_t reg_req_i,
  output ao_periph_pkg::ao_reg_rsp_t reg_rsp_o,
  input  logic [GPIO_W-1:0]          cio_gpio_i,
  output logic [GPIO_W-1:0]          cio_gpio_o,
  output logic [GPIO_W-1:0]          cio_gpio_en_o,
  output logic [GPIO_W-1:0]          intr_gpio_o
);
  import ao_periph_pkg::*;

  ao_reg_rsp_t       rsp_q;
  logic              accept;
  logic              wr_en;
  reg_ofs_t          ofs;
  logic [GPIO_W-1:0] wdata;
  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] en_q;
  logic [GPIO_W-1:0] intr_en_q;
  logic [GPIO_W-1:0] status_q;
  logic [GPIO_W-1:0] sync1_q;
  logic [GPIO_W-1:0] sync2_q;
  logic [GPIO_W-1:0] sync3_q;
  logic [GPIO_W-1:0] rise;
  logic [GPIO_W-1:0] clr_mask;
  logic [DATA_W-1:0] rdata;

  assign accept = reg_req_i.valid && !rsp_q.ready;
  assign wr_en  = accept && reg_req_i.write;
  assign ofs    = reg_req_i.addr[OFS_LSB +: $bits(reg_ofs_t)];
  assign wdata  = reg_req_i.wdata[GPIO_W-1:0];

  // sync3 is the previous synchronised value
  assign rise     = sync2_q & ~sync3_q;
  assign clr_mask = (wr_en && (ofs == GPIO_INTR_STATUS_OFS)) ? wdata : '0;

  always_comb begin
    rdata = '0;
    case (ofs)
      GPIO_IN_OFS:          rdata[GPIO_W-1:0] = sync2_q;
      GPIO_OUT_OFS:         rdata[GPIO_W-1:0] = out_q;
      GPIO_EN_OFS:          rdata[GPIO_W-1:0] = en_q;
      GPIO_INTR_EN_OFS:     rdata[GPIO_W-1:0] = intr_en_q;
      GPIO_INTR_STATUS_OFS: rdata[GPIO_W-1:0] = status_q;
      default:              rdata             = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_q     <= '0;
      out_q     <= '0;
      en_q      <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
      sync1_q   <= '0;
      sync2_q   <= '0;
      sync3_q   <= '0;
    end else begin
      rsp_q.ready <= accept;
      rsp_q.error <= 1'b0;
      rsp_q.rdata <= (accept && !reg_req_i.write) ? rdata : '0;
      sync1_q     <= cio_gpio_i;
      sync2_q     <= sync1_q;
      sync3_q     <= sync2_q;
      if (wr_en && (ofs == GPIO_OUT_OFS)) begin
        out_q <= wdata;
      end
      if (wr_en && (ofs == GPIO_EN_OFS)) begin
        en_q <= wdata;
      end
      if (wr_en && (ofs == GPIO_INTR_EN_OFS)) begin
        intr_en_q <= wdata;
      end
      // A fresh edge beats a clear on the same cycle
      status_q <= (status_q & ~clr_mask) | (rise & intr_en_q);
    end
  end

  assign reg_rsp_o     = rsp_q;
  assign cio_gpio_o    = out_q;
  assign cio_gpio_en_o = en_q;
  assign intr_gpio_o   = status_q;

  // Pads move only when software writes the output register
  a_out_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    !(wr_en && (ofs == GPIO_OUT_OFS)) |=> $stable(cio_gpio_o))
    else $error("gpio_ao: output changed without a write");

endmodule

// File: rtl/fast_intr_ctrl.sv
`timescale 1ns/100ps
// Lines are level-sampled every edge; FAST_INTR_W up to 32
// A line still high while its bit is cleared keeps the bit set
module fast_intr_ctrl #(
  parameter int unsigned FAST_INTR_W = 15
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  ao_periph_pkg::ao_reg_req_t reg_req_i,
  output ao_periph_pkg::ao_reg_rsp_t reg_rsp_o,
  input  logic [FAST_INTR_W-1:0]     fast_intr_i,
  output logic [FAST_INTR_W-1:0]     fast_intr_o
);
  import ao_periph_pkg::*;

  ao_reg_rsp_t            rsp_q;
  logic                   accept;
  logic                   clr_en;
  logic [FAST_INTR_W-1:0] clr_mask;
  logic [FAST_INTR_W-1:0] pending_q;
  logic [DATA_W-1:0]      rdata;

  assign accept = reg_req_i.valid && !rsp_q.ready;
  assign clr_en = accept && reg_req_i.write &&
                  (reg_req_i.addr[OFS_LSB +: $bits(reg_ofs_t)] == FAST_PENDING_OFS);
  assign clr_mask = clr_en ? reg_req_i.wdata[FAST_INTR_W-1:0] : '0;

  // Only one register here, other offsets read as zero
  always_comb begin
    rdata = '0;
    if (reg_req_i.addr[OFS_LSB +: $bits(reg_ofs_t)] == FAST_PENDING_OFS) begin
      rdata[FAST_INTR_W-1:0] = pending_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_q     <= '0;
      pending_q <= '0;
    end else begin
      rsp_q.ready <= accept;
      rsp_q.error <= 1'b0;
      rsp_q.rdata <= (accept && !reg_req_i.write) ? rdata : '0;
      // Set wins over write-one-to-clear
      pending_q   <= (pending_q & ~clr_mask) | fast_intr_i;
    end
  end

  assign reg_rsp_o   = rsp_q;
  assign fast_intr_o = pending_q;

  // Pending bits only drop through a bus write
  a_clear_on_write: assert property (@(posedge clk_i) disable iff (reset_i)
    !clr_en |=> (($past(pending_q) & ~pending_q) == '0))
    else $error("fast_intr_ctrl: pending bit lost without a write");

endmodule

// File: rtl/soc_ctrl.sv
`timescale 1ns/100ps
// Boot straps are read live and zero-extended; writes to them are ignored
module soc_ctrl (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  ao_periph_pkg::ao_reg_req_t reg_req_i,
  output ao_periph_pkg::ao_reg_rsp_t reg_rsp_o,
  input  logic                       boot_select_i,
  input  logic                       execute_from_flash_i,
  output logic                       exit_valid_o,
  output logic [31:0]                exit_value_o
);
  import ao_periph_pkg::*;

  ao_reg_rsp_t       rsp_q;
  logic              accept;
  logic              wr_en;
  reg_ofs_t          ofs;
  logic              exit_valid_q;
  logic [DATA_W-1:0] exit_value_q;
  logic [DATA_W-1:0] rdata;

  // No new access while our response is out
  assign accept = reg_req_i.valid && !rsp_q.ready;
  assign wr_en  = accept && reg_req_i.write;
  assign ofs    = reg_req_i.addr[OFS_LSB +: $bits(reg_ofs_t)];

  always_comb begin
    rdata = '0;
    case (ofs)
      EXIT_VALID_OFS:  rdata[0] = exit_valid_q;
      EXIT_VALUE_OFS:  rdata    = exit_value_q;
      BOOT_SELECT_OFS: rdata[0] = boot_select_i;
      EXEC_FLASH_OFS:  rdata[0] = execute_from_flash_i;
      default:         rdata    = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_q        <= '0;
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else begin
      rsp_q.ready <= accept;
      rsp_q.error <= 1'b0;
      rsp_q.rdata <= (accept && !reg_req_i.write) ? rdata : '0;
      if (wr_en && (ofs == EXIT_VALID_OFS)) begin
        exit_valid_q <= reg_req_i.wdata[0];
      end
      if (wr_en && (ofs == EXIT_VALUE_OFS)) begin
        exit_value_q <= reg_req_i.wdata;
      end
    end
  end

  assign reg_rsp_o    = rsp_q;
  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

  // Responses are single-cycle pulses
  a_ready_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_q.ready |=> !rsp_q.ready)
    else $error("soc_ctrl: ready held for two cycles");

endmodule

// File: rtl/ao_reg_decoder.sv
`timescale 1ns/100ps
// Adds no latency; peripherals answer in one cycle on their own
// Unmapped selects get a one-cycle error response with zero data
module ao_reg_decoder (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  ao_periph_pkg::ao_reg_req_t bus_req_i,
  output ao_periph_pkg::ao_reg_rsp_t bus_rsp_o,
  output ao_periph_pkg::ao_reg_req_t soc_req_o,
  output ao_periph_pkg::ao_reg_req_t fast_req_o,
  output ao_periph_pkg::ao_reg_req_t gpio_req_o,
  input  ao_periph_pkg::ao_reg_rsp_t soc_rsp_i,
  input  ao_periph_pkg::ao_reg_rsp_t fast_rsp_i,
  input  ao_periph_pkg::ao_reg_rsp_t gpio_rsp_i
);
  import ao_periph_pkg::*;

  periph_sel_t sel;
  logic        unmapped;
  logic        err_q;

  assign sel      = bus_req_i.addr[SEL_LSB +: $bits(periph_sel_t)];
  assign unmapped = !(sel inside {SOC_CTRL_SEL, FAST_INTR_SEL, GPIO_SEL});

  // Same request everywhere, valid only to the addressed block
  always_comb begin
    soc_req_o        = bus_req_i;
    fast_req_o       = bus_req_i;
    gpio_req_o       = bus_req_i;
    soc_req_o.valid  = bus_req_i.valid && (sel == SOC_CTRL_SEL);
    fast_req_o.valid = bus_req_i.valid && (sel == FAST_INTR_SEL);
    gpio_req_o.valid = bus_req_i.valid && (sel == GPIO_SEL);
  end

  // Error responder for holes in the map
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= bus_req_i.valid && unmapped && !err_q;
    end
  end

  // Idle responders drive zeros, so a plain OR is enough
  always_comb begin
    bus_rsp_o.ready = soc_rsp_i.ready | fast_rsp_i.ready | gpio_rsp_i.ready | err_q;
    bus_rsp_o.error = soc_rsp_i.error | fast_rsp_i.error | gpio_rsp_i.error | err_q;
    bus_rsp_o.rdata = soc_rsp_i.rdata | fast_rsp_i.rdata | gpio_rsp_i.rdata;
  end

  // Only one access is ever in flight across all responders
  a_single_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({soc_rsp_i.ready, fast_rsp_i.ready, gpio_rsp_i.ready, err_q}))
    else $error("ao_reg_decoder: more than one response ready");

endmodule

// File: rtl/ao_periph_pkg.sv
// Types and address map of the always-on register bus
// Every access is a full 32-bit word; there are no byte enables
package ao_periph_pkg;

  localparam int unsigned DATA_W = 32;

  // Address fields: peripheral select and word offset
  localparam int unsigned SEL_LSB = 12;
  localparam int unsigned OFS_LSB = 2;

  typedef struct packed {
    logic              valid;
    logic              write;
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } ao_reg_req_t;

  typedef struct packed {
    logic              ready;
    logic              error;
    logic [DATA_W-1:0] rdata;
  } ao_reg_rsp_t;

  typedef logic [3:0] periph_sel_t;
  typedef logic [2:0] reg_ofs_t;

  // Mapped regions, anything else is answered with an error
  localparam periph_sel_t SOC_CTRL_SEL  = 4'd0;
  localparam periph_sel_t FAST_INTR_SEL = 4'd1;
  localparam periph_sel_t GPIO_SEL      = 4'd2;

  // SoC control
  localparam reg_ofs_t EXIT_VALID_OFS  = 3'd0;
  localparam reg_ofs_t EXIT_VALUE_OFS  = 3'd1;
  localparam reg_ofs_t BOOT_SELECT_OFS = 3'd2;
  localparam reg_ofs_t EXEC_FLASH_OFS  = 3'd3;

  // Fast interrupt controller
  localparam reg_ofs_t FAST_PENDING_OFS = 3'd0;

  // GPIO
  localparam reg_ofs_t GPIO_IN_OFS          = 3'd0;
  localparam reg_ofs_t GPIO_OUT_OFS         = 3'd1;
  localparam reg_ofs_t GPIO_EN_OFS          = 3'd2;
  localparam reg_ofs_t GPIO_INTR_EN_OFS     = 3'd3;
  localparam reg_ofs_t GPIO_INTR_STATUS_OFS = 3'd4;

endpackage
